// ==== rtl/carrier_sense.sv ====
`timescale 1ns/1ps

module carrier_sense
   import cs_pkg::*;
(
   input  logic    dsp_clk,
   input  logic    por_rst,
   input  logic    rx_run_i,
   input  sample_t samp_i_i,
   input  sample_t samp_q_i,
   input  logic    samp_stb_i,
   input  thresh_t threshold_i,
   output logic    carrier_o,
   output count_t  quiet_count_o
);

   ////////////////////////////////////////////////////////////////////
   // Stage one, sample energy

   logic signed [31:0] sq_i;
   logic signed [31:0] sq_q;
   energy_t            energy;
   logic               s1_valid;

   // Squares are never negative, so widening as unsigned is safe
   assign sq_i = samp_i_i * samp_i_i;
   assign sq_q = samp_q_i * samp_q_i;

   always_ff @(posedge dsp_clk) begin
      if (samp_stb_i) begin
         energy <= energy_t'(unsigned'(sq_i)) + energy_t'(unsigned'(sq_q));
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= samp_stb_i;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Stage two, threshold and quiet counter

   logic above;

   assign above = energy > energy_t'(threshold_i);

   always_ff @(posedge dsp_clk) begin
      if (por_rst || !rx_run_i) begin
         // Receiver off, no carrier and no quiet history
         carrier_o     <= 1'b0;
         quiet_count_o <= '0;
      end else if (s1_valid) begin
         carrier_o <= above;
         if (above) begin
            quiet_count_o <= '0;
         end else if (quiet_count_o != '1) begin
            quiet_count_o <= quiet_count_o + count_t'(1);
         end
      end
   end

endmodule

// ==== rtl/cs_pkg.sv ====
package cs_pkg;

   ////////////////////////////////////////////////////////////////////
   // Settings bus

   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   // Register map
   // CTRL bit 0 is rx_run, bit 1 is tx_enable
   localparam logic [SET_ADDR_W-1:0] SR_CS_CTRL    = 8'd24;
   localparam logic [SET_ADDR_W-1:0] SR_CS_THRESH  = 8'd25;
   localparam logic [SET_ADDR_W-1:0] SR_CS_HOLDOFF = 8'd26;

   ////////////////////////////////////////////////////////////////////
   // Datapath

   // Raw converter word
   localparam int ADC_W = 14;

   // One I or Q sample after widening
   typedef logic signed [15:0] sample_t;

   // I*I + Q*Q, one bit wider than a single square
   typedef logic [32:0] energy_t;

   typedef logic [31:0] thresh_t;

   // Quiet sample count and hold-off share this type
   typedef logic [15:0] count_t;

   ////////////////////////////////////////////////////////////////////
   // Transmit gate

   typedef enum logic [1:0] {
      GATE_IDLE   = 2'd0,
      GATE_LISTEN = 2'd1,
      GATE_SEND   = 2'd2
   } gate_state_t;

endpackage

// ==== rtl/cs_settings.sv ====
`timescale 1ns/1ps

module cs_settings
   import cs_pkg::*;
(
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  logic                  set_stb_i,
   input  logic [SET_ADDR_W-1:0] set_addr_i,
   input  logic [SET_DATA_W-1:0] set_data_i,
   output logic                  rx_run_o,
   output logic                  tx_enable_o,
   output thresh_t               threshold_o,
   output count_t                holdoff_o
);

   // Address decode for each register
   logic wr_ctrl;
   logic wr_thresh;
   logic wr_holdoff;

   assign wr_ctrl    = set_stb_i && (set_addr_i == SR_CS_CTRL);
   assign wr_thresh  = set_stb_i && (set_addr_i == SR_CS_THRESH);
   assign wr_holdoff = set_stb_i && (set_addr_i == SR_CS_HOLDOFF);

   // Control bits
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rx_run_o    <= 1'b0;
         tx_enable_o <= 1'b0;
      end else if (wr_ctrl) begin
         rx_run_o    <= set_data_i[0];
         tx_enable_o <= set_data_i[1];
      end
   end

   // Threshold starts at all ones so nothing counts as a carrier
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         threshold_o <= '1;
      end else if (wr_thresh) begin
         threshold_o <= thresh_t'(set_data_i);
      end
   end

   // Hold-off in quiet samples, lower half of the data word
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         holdoff_o <= '0;
      end else if (wr_holdoff) begin
         holdoff_o <= set_data_i[15:0];
      end
   end

endmodule

// ==== rtl/csma_core.sv ====
`timescale 1ns/1ps

module csma_core (
   input  logic        dsp_clk,
   input  logic        por_rst,

   // Settings writes
   input  logic        set_stb_i,
   input  logic [7:0]  set_addr_i,
   input  logic [31:0] set_data_i,

   // Converter inputs
   input  logic [13:0] adc_a_i,
   input  logic [13:0] adc_b_i,

   // Transmit side
   input  logic [15:0] tx_i_i,
   input  logic [15:0] tx_q_i,
   input  logic        tx_req_i,

   output logic [15:0] dac_a_o,
   output logic [15:0] dac_b_o,
   output logic        carrier_o,
   output logic        tx_run_o
);

   logic        rx_run;
   logic        tx_enable;
   logic [31:0] threshold;
   logic [15:0] holdoff;

   logic [15:0] samp_i;
   logic [15:0] samp_q;
   logic        samp_stb;

   logic [15:0] quiet_count;

   ////////////////////////////////////////////////////////////////////
   // Settings

   cs_settings u_settings (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .rx_run_o    (rx_run),
      .tx_enable_o (tx_enable),
      .threshold_o (threshold),
      .holdoff_o   (holdoff)
   );

   ////////////////////////////////////////////////////////////////////
   // Receive path

   rx_frontend u_rx_frontend (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .rx_run_i   (rx_run),
      .adc_a_i    (adc_a_i),
      .adc_b_i    (adc_b_i),
      .samp_i_o   (samp_i),
      .samp_q_o   (samp_q),
      .samp_stb_o (samp_stb)
   );

   // Carrier flag goes straight out
   carrier_sense u_carrier_sense (
      .dsp_clk       (dsp_clk),
      .por_rst       (por_rst),
      .rx_run_i      (rx_run),
      .samp_i_i      (samp_i),
      .samp_q_i      (samp_q),
      .samp_stb_i    (samp_stb),
      .threshold_i   (threshold),
      .carrier_o     (carrier_o),
      .quiet_count_o (quiet_count)
   );

   ////////////////////////////////////////////////////////////////////
   // Transmit path

   tx_gate u_tx_gate (
      .dsp_clk       (dsp_clk),
      .por_rst       (por_rst),
      .tx_enable_i   (tx_enable),
      .tx_req_i      (tx_req_i),
      .quiet_count_i (quiet_count),
      .holdoff_i     (holdoff),
      .tx_i_i        (tx_i_i),
      .tx_q_i        (tx_q_i),
      .dac_a_o       (dac_a_o),
      .dac_b_o       (dac_b_o),
      .tx_run_o      (tx_run_o)
   );

endmodule

// ==== rtl/rx_frontend.sv ====
`timescale 1ns/1ps

module rx_frontend
   import cs_pkg::*;
(
   input  logic             dsp_clk,
   input  logic             por_rst,
   input  logic             rx_run_i,
   input  logic [ADC_W-1:0] adc_a_i,
   input  logic [ADC_W-1:0] adc_b_i,
   output sample_t          samp_i_o,
   output sample_t          samp_q_o,
   output logic             samp_stb_o
);

   // Converter words left-justified in a 16-bit sample
   sample_t wide_a;
   sample_t wide_b;

   assign wide_a = sample_t'({adc_a_i, 2'b00});
   assign wide_b = sample_t'({adc_b_i, 2'b00});

   // Capture only while receive runs, hold last pair otherwise
   always_ff @(posedge dsp_clk) begin
      if (rx_run_i) begin
         samp_i_o <= wide_a;
         samp_q_o <= wide_b;
      end
   end

   // Strobe follows run with the same one-cycle latency as the data
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         samp_stb_o <= 1'b0;
      end else begin
         samp_stb_o <= rx_run_i;
      end
   end

endmodule

// ==== rtl/tx_gate.sv ====
`timescale 1ns/1ps

module tx_gate
   import cs_pkg::*;
(
   input  logic    dsp_clk,
   input  logic    por_rst,
   input  logic    tx_enable_i,
   input  logic    tx_req_i,
   input  count_t  quiet_count_i,
   input  count_t  holdoff_i,
   input  sample_t tx_i_i,
   input  sample_t tx_q_i,
   output sample_t dac_a_o,
   output sample_t dac_b_o,
   output logic    tx_run_o
);

   gate_state_t state;
   gate_state_t state_next;

   // Request counts only while transmit is enabled
   logic tx_go;
   logic chan_clear;

   assign tx_go      = tx_req_i && tx_enable_i;
   assign chan_clear = quiet_count_i >= holdoff_i;

   ////////////////////////////////////////////////////////////////////
   // Listen-before-talk FSM

   always_comb begin
      state_next = state;
      unique case (state)
         GATE_IDLE: begin
            if (tx_go) begin
               state_next = GATE_LISTEN;
            end
         end
         GATE_LISTEN: begin
            if (!tx_go) begin
               state_next = GATE_IDLE;
            end else if (chan_clear) begin
               state_next = GATE_SEND;
            end
         end
         GATE_SEND: begin
            // A carrier here does not abort, only the request ends it
            if (!tx_go) begin
               state_next = GATE_IDLE;
            end
         end
         default: begin
            state_next = GATE_IDLE;
         end
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state <= GATE_IDLE;
      end else begin
         state <= state_next;
      end
   end

   assign tx_run_o = (state == GATE_SEND);

   ////////////////////////////////////////////////////////////////////
   // DAC output registers

   // Loaded from the next state so the DAC is zero exactly when not sending
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         dac_a_o <= '0;
         dac_b_o <= '0;
      end else if (state_next == GATE_SEND) begin
         dac_a_o <= tx_i_i;
         dac_b_o <= tx_q_i;
      end else begin
         dac_a_o <= '0;
         dac_b_o <= '0;
      end
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the csma_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f verilog.f --top-module tb_csma_core -Mdir obj_dir -o sim_csma
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_csma > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
   echo "Simulation reported errors"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
echo "Simulation finished cleanly"
exit 0

// ==== test/csma_tests.txt ====
# op   name           arg1  arg2      arg3    all numbers hex
# wr: addr data 0 | adc: adc_a adc_b carrier | rnd: count 0 0 | tx: tx_i tx_q send | end: keep_req 0 0
wr   rx_on          18    00000001  0
adc  below_max      1fff  1fff      0
adc  below_min      2000  2000      0
wr   thresh_1m      19    00100000  0
adc  quiet_small    0010  0010      0
adc  carrier_on     0200  0000      1
adc  carrier_off    0010  0000      0
adc  neg_pair       3e00  0100      1
adc  at_thresh      0100  0000      0
adc  over_thresh    0100  0001      1
wr   thresh_8m      19    00800000  0
adc  thresh_raised  0200  0000      0
wr   thresh_512m    19    20000000  0
rnd  random         28    0         0
wr   holdoff_20     1a    00000014  0
wr   tx_on          18    00000003  0
adc  busy           1800  1800      1
tx   defer          1234  5678      0
adc  go_quiet       0004  0004      0
tx   send           1234  5678      1
end  drop_req       0     0         0
tx   resend         0abc  0def      1
wr   tx_off         18    00000001  0
end  disable        1     0         0
wr   rx_off         18    00000000  0
adc  rx_idle        1800  1800      0

// ==== test/tb_csma_core.sv ====
`timescale 1ns/1ps

module tb_csma_core
   import cs_pkg::*;
();

   typedef logic [127:0] name_t;

   localparam int WAIT_MAX     = 200;
   localparam int DEFER_CYCLES = 40;

   logic                  dsp_clk;
   logic                  por_rst;
   logic                  set_stb;
   logic [SET_ADDR_W-1:0] set_addr;
   logic [SET_DATA_W-1:0] set_data;
   logic [ADC_W-1:0]      adc_a;
   logic [ADC_W-1:0]      adc_b;
   sample_t               tx_i;
   sample_t               tx_q;
   logic                  tx_req;
   sample_t               dac_a;
   sample_t               dac_b;
   logic                  carrier;
   logic                  tx_run;

   // Expected register contents
   logic    m_rx_run;
   thresh_t m_thresh;
   count_t  m_holdoff;

   // Carrier history for the latency checks
   logic   prev_flag;
   logic   prev_known;
   logic   last_drive;
   int     quiet_start;
   int     cyc;
   integer seed;

   csma_core u_csma_core (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .set_stb_i  (set_stb),
      .set_addr_i (set_addr),
      .set_data_i (set_data),
      .adc_a_i    (adc_a),
      .adc_b_i    (adc_b),
      .tx_i_i     (tx_i),
      .tx_q_i     (tx_q),
      .tx_req_i   (tx_req),
      .dac_a_o    (dac_a),
      .dac_b_o    (dac_b),
      .carrier_o  (carrier),
      .tx_run_o   (tx_run)
   );

   always #2 dsp_clk = ~dsp_clk;

   ////////////////////////////////////////////////////////////////////
   // Helpers

   task automatic next_cycle;
      @(posedge dsp_clk);
      #1;
      cyc++;
   endtask

   task automatic end_with_failure;
      $display("Done: errors found");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_carrier(input name_t name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("FAILED %0s: carrier expected %0b, actual %0b", name, expected, actual);
         end_with_failure();
      end
   endtask

   task automatic check_dac(input name_t name, input sample_t expected, input sample_t actual);
      if (actual !== expected) begin
         $display("FAILED %0s: dac expected %0d, actual %0d", name, expected, actual);
         end_with_failure();
      end
   endtask

   task automatic check_run(input name_t name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("FAILED %0s: tx_run expected %0b, actual %0b", name, expected, actual);
         end_with_failure();
      end
   endtask

   // Widen by two zero bits, then compare I*I + Q*Q against the threshold
   function automatic logic energy_above(input logic [ADC_W-1:0] a, input logic [ADC_W-1:0] b,
                                        input thresh_t th);
      longint wa;
      longint wb;
      wa = longint'($signed(a)) * 4;
      wb = longint'($signed(b)) * 4;
      return (wa * wa + wb * wb) > longint'(th);
   endfunction

   task automatic wait_run(input name_t name, input logic level);
      int n;
      n = 0;
      while (tx_run !== level && n < WAIT_MAX) begin
         next_cycle();
         n++;
      end
      if (tx_run !== level) begin
         $display("Timeout in %0s: tx_run_o never went to %0b", name, level);
         end_with_failure();
      end
   endtask

   task automatic write_setting(input logic [SET_ADDR_W-1:0] addr,
                                input logic [SET_DATA_W-1:0] data);
      set_stb  = 1'b1;
      set_addr = addr;
      set_data = data;
      next_cycle();
      set_stb = 1'b0;
      if (addr == SR_CS_CTRL) begin
         m_rx_run = data[0];
         if (!data[0]) begin
            prev_flag = 1'b0;
         end
      end else if (addr == SR_CS_THRESH) begin
         // Held pair may flip early against the new threshold
         m_thresh   = data;
         prev_known = 1'b0;
      end else if (addr == SR_CS_HOLDOFF) begin
         m_holdoff = data[15:0];
      end
   endtask

   task automatic drive_pair(input name_t name, input logic [ADC_W-1:0] a,
                             input logic [ADC_W-1:0] b, input logic flag);
      adc_a = a;
      adc_b = b;
      if (last_drive && !flag) begin
         quiet_start = cyc;
      end
      last_drive = flag;
      next_cycle();
      next_cycle();
      // One cycle early the old flag is still out
      if (prev_known) begin
         check_carrier(name, prev_flag, carrier);
      end
      next_cycle();
      check_carrier(name, flag, carrier);
      prev_flag  = flag;
      prev_known = 1'b1;
   endtask

   task automatic request_tx(input name_t name, input sample_t si, input sample_t sq,
                             input logic send);
      int rise;
      tx_i   = si;
      tx_q   = sq;
      tx_req = 1'b1;
      if (!send) begin
         for (int k = 0; k < DEFER_CYCLES; k++) begin
            next_cycle();
            check_run(name, 1'b0, tx_run);
            check_dac(name, '0, dac_a);
            check_dac(name, '0, dac_b);
         end
         tx_req = 1'b0;
      end else begin
         wait_run(name, 1'b1);
         rise = cyc;
         if (rise - quiet_start < int'(m_holdoff) + 3) begin
            $display("In %0s tx_run_o rose %0d cycles after quiet input, hold-off is %0d",
                     name, rise - quiet_start, m_holdoff);
            end_with_failure();
         end
         check_dac(name, si, dac_a);
         check_dac(name, sq, dac_b);
         tx_i = ~si;
         tx_q = ~sq;
         next_cycle();
         check_run(name, 1'b1, tx_run);
         check_dac(name, ~si, dac_a);
         check_dac(name, ~sq, dac_b);
      end
   endtask

   task automatic end_tx(input name_t name, input logic keep_req);
      if (!keep_req) begin
         tx_req = 1'b0;
      end
      wait_run(name, 1'b0);
      check_dac(name, '0, dac_a);
      check_dac(name, '0, dac_b);
      tx_req = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      int            fd;
      int            n;
      logic [1023:0] line;
      name_t         op;
      name_t         name;
      logic [31:0]   a_v;
      logic [31:0]   b_v;
      logic [31:0]   c_v;
      logic [31:0]   r;
      dsp_clk     = 1'b0;
      por_rst     = 1'b1;
      set_stb     = 1'b0;
      set_addr    = '0;
      set_data    = '0;
      adc_a       = '0;
      adc_b       = '0;
      tx_i        = '0;
      tx_q        = '0;
      tx_req      = 1'b0;
      m_rx_run    = 1'b0;
      m_thresh    = '1;
      m_holdoff   = '0;
      prev_flag   = 1'b0;
      prev_known  = 1'b1;
      last_drive  = 1'b0;
      quiet_start = 0;
      cyc         = 0;
      seed        = 31;
      next_cycle();
      next_cycle();
      por_rst = 1'b0;
      check_carrier(name_t'("reset"), 1'b0, carrier);
      check_run(name_t'("reset"), 1'b0, tx_run);
      check_dac(name_t'("reset"), '0, dac_a);
      check_dac(name_t'("reset"), '0, dac_b);

      fd = $fopen("test/csma_tests.txt", "r");
      if (fd == 0) begin
         $display("Could not open test/csma_tests.txt");
         end_with_failure();
      end
      while (!$feof(fd)) begin
         line = '0;
         op   = '0;
         n    = $fgets(line, fd);
         n    = $sscanf(line, "%s %s %h %h %h", op, name, a_v, b_v, c_v);
         if (n == 5 && op != name_t'("#")) begin
            if (op == name_t'("wr")) begin
               write_setting(a_v[7:0], b_v);
            end else if (op == name_t'("adc")) begin
               drive_pair(name, a_v[13:0], b_v[13:0], c_v[0]);
            end else if (op == name_t'("rnd")) begin
               for (int k = 0; k < int'(a_v); k++) begin
                  r = $random(seed);
                  drive_pair(name, r[13:0], r[29:16],
                             m_rx_run && energy_above(r[13:0], r[29:16], m_thresh));
               end
            end else if (op == name_t'("tx")) begin
               request_tx(name, a_v[15:0], b_v[15:0], c_v[0]);
            end else if (op == name_t'("end")) begin
               end_tx(name, a_v[0]);
            end else begin
               $display("Unknown operation %0s in the test file", op);
               end_with_failure();
            end
         end
      end
      $fclose(fd);
      $display("Done: no errors");
      $finish;
   end

endmodule

// ==== verilog.f ====
rtl/cs_pkg.sv
rtl/cs_settings.sv
rtl/rx_frontend.sv
rtl/carrier_sense.sv
rtl/tx_gate.sv
rtl/csma_core.sv
test/tb_csma_core.sv
